/* common/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

//////////////////////////////
// memory sizes
//////////////////////////////

// instruction memory, 2**IMEM_AW words
`define IMEM_AW 6

// data memory, 2**DMEM_AW words
`define DMEM_AW 6

//////////////////////////////
// fetch
//////////////////////////////

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* common/mips_pkg.sv */
package mips_pkg;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    dst_rt;
        alu_op_t alu_op;
    } ctrl_t;

    //////////////////////////////
    // stage payloads
    //////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_plus4;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [4:0]  dst;
        logic [31:0] alu_result;
        logic [31:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_to_reg;
        logic [4:0]  dst;
        logic [31:0] alu_result;
        logic [31:0] load_data;
    } mem_wb_t;

    //////////////////////////////
    // events and load port
    //////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_event_t;

    // addr is a word address
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } store_event_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] instr;
    } imem_load_t;

endpackage

/* decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  if_id_t      if_id,
    input  id_ex_t      id_ex_q,
    input  ex_mem_t     ex_mem_q,
    input  wb_event_t   wb_event,
    output id_ex_t      id_ex,
    output logic        pc_hold,
    output logic        ifid_hold,
    output logic        ifid_squash,
    output logic        idex_squash,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2a;

    opcode_t     opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm;
    ctrl_t       ctrl;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic        uses_rs;
    logic        uses_rt;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic        idex_hit;
    logic        exmem_load_hit;
    logic        stall;
    logic        taken;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    wb_event_t   rf_wr;

    assign opcode = opcode_t'(if_id.instr[31:26]);
    assign funct  = if_id.instr[5:0];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign imm    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

    //////////////////////////////
    // control decode
    //////////////////////////////

    always_comb begin
        ctrl    = '0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_j    = 1'b0;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        if (if_id.valid) begin
            case (opcode)
                op_rtype: begin
                    uses_rs        = 1'b1;
                    uses_rt        = 1'b1;
                    ctrl.reg_write = 1'b1;
                    case (funct)
                        FUNCT_ADD: ctrl.alu_op = alu_add;
                        FUNCT_SUB: ctrl.alu_op = alu_sub;
                        FUNCT_AND: ctrl.alu_op = alu_and;
                        FUNCT_OR:  ctrl.alu_op = alu_or;
                        FUNCT_SLT: ctrl.alu_op = alu_slt;
                        // unknown funct acts as a nop
                        default:   ctrl.reg_write = 1'b0;
                    endcase
                end
                op_addi, op_lw: begin
                    uses_rs          = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = (opcode == op_lw);
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.dst_rt      = 1'b1;
                end
                op_sw: begin
                    uses_rs          = 1'b1;
                    uses_rt          = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                op_beq, op_bne: begin
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                    is_beq  = (opcode == op_beq);
                    is_bne  = (opcode == op_bne);
                end
                op_j: is_j = 1'b1;
                default: ;
            endcase
        end
    end

    // no writes land while the core is held in reset
    always_comb begin
        rf_wr       = wb_event;
        rf_wr.valid = wb_event.valid && rst_n;
    end

    reg_file u_reg_file (
        .clk     (clk),
        .rs      (rs),
        .rt      (rt),
        .wr      (rf_wr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    //////////////////////////////
    // hazards
    //////////////////////////////

    assign idex_hit = id_ex_q.valid && id_ex_q.ctrl.reg_write && (id_ex_q.dst != 5'd0) &&
        ((uses_rs && id_ex_q.dst == rs) || (uses_rt && id_ex_q.dst == rt));

    // load data is not ready in EX/MEM, a branch has to wait one more cycle
    assign exmem_load_hit = ex_mem_q.valid && ex_mem_q.ctrl.mem_read &&
        (ex_mem_q.dst != 5'd0) && ((uses_rs && ex_mem_q.dst == rs) ||
        (uses_rt && ex_mem_q.dst == rt));

    assign stall = (idex_hit && id_ex_q.ctrl.mem_read) ||
        ((is_beq || is_bne) && (idex_hit || exmem_load_hit));

    //////////////////////////////
    // branch and jump
    //////////////////////////////

    assign cmp_a = (ex_mem_q.valid && ex_mem_q.ctrl.reg_write && (rs != 5'd0) &&
        ex_mem_q.dst == rs) ? ex_mem_q.alu_result : rs_data;
    assign cmp_b = (ex_mem_q.valid && ex_mem_q.ctrl.reg_write && (rt != 5'd0) &&
        ex_mem_q.dst == rt) ? ex_mem_q.alu_result : rt_data;

    assign taken = is_j || (is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b);

    assign branch_target = if_id.pc_plus4 + {imm[29:0], 2'b00};
    assign jump_target   = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};

    assign redirect    = taken && !stall;
    assign redirect_pc = is_j ? jump_target : branch_target;
    assign pc_hold     = stall;
    assign ifid_hold   = stall;
    assign idex_squash = stall;
    assign ifid_squash = redirect;

    always_comb begin
        id_ex.valid   = if_id.valid;
        id_ex.ctrl    = ctrl;
        id_ex.rs      = rs;
        id_ex.rt      = rt;
        id_ex.dst     = ctrl.dst_rt ? rt : rd;
        id_ex.rs_data = rs_data;
        id_ex.rt_data = rt_data;
        id_ex.imm     = imm;
    end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic        clk,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  wb_event_t   wr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (wr.valid && (wr.rd != 5'd0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // the value being written back shows up in the same cycle
    assign rs_data = (rs == 5'd0)              ? 32'd0   :
                     (wr.valid && wr.rd == rs) ? wr.data :
                                                 regs[rs];

    assign rt_data = (rt == 5'd0)              ? 32'd0   :
                     (wr.valid && wr.rd == rt) ? wr.data :
                                                 regs[rt];

endmodule

/* design/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  imem_load_t   imem_load,
    output wb_event_t    wb_event,
    output store_event_t store_event
);

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    logic        pc_hold;
    logic        ifid_hold;
    logic        ifid_squash;
    logic        idex_squash;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] load_data;
    logic [31:0] wb_data;

    //////////////////////////////
    // fetch
    //////////////////////////////

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_load   (imem_load),
        .pc_hold     (pc_hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_id       (if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (ifid_hold),
        .squash (ifid_squash),
        .d      (if_id_d),
        .q      (if_id_q)
    );

    //////////////////////////////
    // decode
    //////////////////////////////

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_id       (if_id_q),
        .id_ex_q     (id_ex_q),
        .ex_mem_q    (ex_mem_q),
        .wb_event    (wb_event),
        .id_ex       (id_ex_d),
        .pc_hold     (pc_hold),
        .ifid_hold   (ifid_hold),
        .ifid_squash (ifid_squash),
        .idex_squash (idex_squash),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // a stall leaves a bubble here
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .squash (idex_squash),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    //////////////////////////////
    // execute and memory
    //////////////////////////////

    execute_stage u_execute (
        .id_ex    (id_ex_q),
        .ex_mem_q (ex_mem_q),
        .mem_wb_q (mem_wb_q),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .squash (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    data_mem u_data_mem (
        .clk         (clk),
        .ex_mem_q    (ex_mem_q),
        .load_data   (load_data),
        .store_event (store_event)
    );

    always_comb begin
        mem_wb_d.valid      = ex_mem_q.valid;
        mem_wb_d.reg_write  = ex_mem_q.ctrl.reg_write;
        mem_wb_d.mem_to_reg = ex_mem_q.ctrl.mem_read;
        mem_wb_d.dst        = ex_mem_q.dst;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = load_data;
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .squash (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    //////////////////////////////
    // writeback
    //////////////////////////////

    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    // writes to r0 are dropped, so no event for them
    always_comb begin
        wb_event.valid = mem_wb_q.valid && mem_wb_q.reg_write && (mem_wb_q.dst != 5'd0);
        wb_event.rd    = mem_wb_q.dst;
        wb_event.data  = wb_data;
    end

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     squash,
    input  payload_t d,
    output payload_t q
);

    // squash beats hold, an all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || squash) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  id_ex_t      id_ex,
    input  ex_mem_t     ex_mem_q,
    input  mem_wb_t     mem_wb_q,
    input  logic [31:0] wb_data,
    output ex_mem_t     ex_mem
);

    logic [31:0] op_a;
    logic [31:0] fwd_b;
    logic [31:0] op_b;
    logic [31:0] result;

    // newest producer first, r0 never forwarded
    function automatic logic [31:0] forward(
        input logic [4:0]  src,
        input logic [31:0] reg_data,
        input ex_mem_t     em,
        input mem_wb_t     mw,
        input logic [31:0] mw_data
    );
        if (src != 5'd0 && em.valid && em.ctrl.reg_write && em.dst == src) begin
            return em.alu_result;
        end else if (src != 5'd0 && mw.valid && mw.reg_write && mw.dst == src) begin
            return mw_data;
        end
        return reg_data;
    endfunction

    assign op_a  = forward(id_ex.rs, id_ex.rs_data, ex_mem_q, mem_wb_q, wb_data);
    assign fwd_b = forward(id_ex.rt, id_ex.rt_data, ex_mem_q, mem_wb_q, wb_data);
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

    //////////////////////////////
    // alu
    //////////////////////////////

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_slt: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            default: result = op_a + op_b;
        endcase
    end

    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.ctrl       = id_ex.ctrl;
        ex_mem.dst        = id_ex.dst;
        ex_mem.alu_result = result;
        // sw data follows the same forwarding as rt
        ex_mem.store_data = fwd_b;
    end

endmodule

/* fetch/fetch_stage.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetch_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  imem_load_t  imem_load,
    input  logic        pc_hold,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output if_id_t      if_id
);

    logic [31:0] imem [2**`IMEM_AW];
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;

    // program load only while the core sits in reset
    always_ff @(posedge clk) begin
        if (!rst_n && imem_load.valid) begin
            imem[imem_load.addr[`IMEM_AW-1:0]] <= imem_load.instr;
        end
    end

    assign pc_plus4 = pc + 32'd4;

    // decode never redirects while it stalls
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (pc_hold) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        if_id.valid    = 1'b1;
        if_id.pc_plus4 = pc_plus4;
        if_id.instr    = imem[pc[`IMEM_AW+1:2]];
    end

endmodule

/* memory/data_mem.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module data_mem import mips_pkg::*; (
    input  logic         clk,
    input  ex_mem_t      ex_mem_q,
    output logic [31:0]  load_data,
    output store_event_t store_event
);

    logic [31:0]         mem [2**`DMEM_AW];
    logic [`DMEM_AW-1:0] word_addr;
    logic                store;

    // byte address in, low two bits dropped
    assign word_addr = ex_mem_q.alu_result[`DMEM_AW+1:2];
    assign store     = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (store) begin
            mem[word_addr] <= ex_mem_q.store_data;
        end
    end

    assign load_data = mem[word_addr];

    always_comb begin
        store_event.valid = store;
        store_event.addr  = {2'b00, ex_mem_q.alu_result[31:2]};
        store_event.data  = ex_mem_q.store_data;
    end

endmodule

/* tb.f */
+incdir+common
+incdir+verification
common/mips_pkg.sv
design/pipe_reg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/data_mem.sv
design/mips_core.sv
verification/tb_mips_core.sv

/* verification/tb_mips_prog.svh */
`ifndef TB_MIPS_PROG_SVH
`define TB_MIPS_PROG_SVH

localparam int PROG_LEN = 20;
localparam int WB_COUNT = 11;
localparam int ST_COUNT = 2;

logic [31:0]  prog   [PROG_LEN];
wb_event_t    exp_wb [WB_COUNT];
store_event_t exp_st [ST_COUNT];

task automatic fill_tables();
    // addi r1, r0, 12 / addi r2, r0, -5
    prog[0]  = 32'h2001_000c;
    prog[1]  = 32'h2002_fffb;
    // add r3,r1,r2 / sub r4,r2,r3 / and r5,r4,r1 / or r6,r5,r2 / slt r7,r4,r2
    prog[2]  = 32'h0022_1820;
    prog[3]  = 32'h0043_2022;
    prog[4]  = 32'h0081_2824;
    prog[5]  = 32'h00a2_3025;
    prog[6]  = 32'h0082_382a;
    // addi r8, r0, 16 / sw r3, 4(r8) / lw r9, 4(r8) / add r10, r9, r1
    prog[7]  = 32'h2008_0010;
    prog[8]  = 32'had03_0004;
    prog[9]  = 32'h8d09_0004;
    prog[10] = 32'h0121_5020;
    // beq r10, r10, +1 skips addi r11 / bne r9, r3, +5 falls through
    prog[11] = 32'h114a_0001;
    prog[12] = 32'h200b_0063;
    prog[13] = 32'h1523_0005;
    // addi r0, r0, 7 / add r12, r0, r1
    prog[14] = 32'h2000_0007;
    prog[15] = 32'h0001_6020;
    // j 18 skips addi r13 / sw r12, 0(r8) / j 19 spins
    prog[16] = 32'h0800_0012;
    prog[17] = 32'h200d_0037;
    prog[18] = 32'had0c_0000;
    prog[19] = 32'h0800_0013;

    // valid, rd, data in program order
    exp_wb[0]  = '{1'b1, 5'd1,  32'h0000_000c};
    exp_wb[1]  = '{1'b1, 5'd2,  32'hffff_fffb};
    exp_wb[2]  = '{1'b1, 5'd3,  32'h0000_0007};
    exp_wb[3]  = '{1'b1, 5'd4,  32'hffff_fff4};
    exp_wb[4]  = '{1'b1, 5'd5,  32'h0000_0004};
    exp_wb[5]  = '{1'b1, 5'd6,  32'hffff_ffff};
    exp_wb[6]  = '{1'b1, 5'd7,  32'h0000_0001};
    exp_wb[7]  = '{1'b1, 5'd8,  32'h0000_0010};
    exp_wb[8]  = '{1'b1, 5'd9,  32'h0000_0007};
    exp_wb[9]  = '{1'b1, 5'd10, 32'h0000_0013};
    exp_wb[10] = '{1'b1, 5'd12, 32'h0000_000c};

    // valid, word address, data
    exp_st[0] = '{1'b1, 32'd5, 32'h0000_0007};
    exp_st[1] = '{1'b1, 32'd4, 32'h0000_000c};
endtask

`endif

/* verification/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    localparam int TIMEOUT      = 200;
    localparam int QUIET_CYCLES = 20;
    localparam int FIRST_WB     = 4;

    logic         clk;
    logic         rst_n;
    imem_load_t   imem_load;
    wb_event_t    wb_event;
    store_event_t store_event;
    int           wb_idx;
    int           st_idx;
    int           cycles;

    `include "tb_mips_prog.svh"

    mips_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_load   (imem_load),
        .wb_event    (wb_event),
        .store_event (store_event)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // an idle expectation only looks at the strobe
    task automatic check_wb(input string name, input wb_event_t exp, input wb_event_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            abort_run($sformatf("FAILED %s expected valid=%b r%0d=%h actual valid=%b r%0d=%h",
                name, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data));
        end
    endtask

    task automatic check_store(input string name, input store_event_t exp,
                               input store_event_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            abort_run($sformatf("FAILED %s expected valid=%b [%0d]=%h actual valid=%b [%0d]=%h",
                name, exp.valid, exp.addr, exp.data, act.valid, act.addr, act.data));
        end
    endtask

    // events are matched in order against the tables
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_event.valid !== 1'b0) begin
                if (wb_idx >= WB_COUNT) begin
                    abort_run("a writeback event came after the expected list ran out");
                end else begin
                    check_wb($sformatf("writeback %0d", wb_idx), exp_wb[wb_idx], wb_event);
                    wb_idx++;
                end
            end
            if (store_event.valid !== 1'b0) begin
                if (st_idx >= ST_COUNT) begin
                    abort_run("a store event came after the expected list ran out");
                end else begin
                    check_store($sformatf("store %0d", st_idx), exp_st[st_idx], store_event);
                    st_idx++;
                end
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        rst_n     = 1'b0;
        imem_load = '0;
        wb_idx    = 0;
        st_idx    = 0;
        cycles    = 0;
        fill_tables();

        // one program word per cycle under reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            imem_load <= '{valid: 1'b1, addr: i, instr: prog[i]};
        end
        @(posedge clk);
        imem_load <= '0;
        // reset held four cycles past the load
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_wb("reset idle", '0, wb_event);
        check_store("reset idle", '0, store_event);
        @(posedge clk);
        rst_n <= 1'b1;

        // first instruction needs four cycles to reach writeback
        for (int i = 0; i < FIRST_WB; i++) begin
            @(negedge clk);
            check_wb("no early writeback", '0, wb_event);
            check_store("no early store", '0, store_event);
        end

        while ((wb_idx < WB_COUNT || st_idx < ST_COUNT) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (wb_idx < WB_COUNT || st_idx < ST_COUNT) begin
            abort_run($sformatf("timed out with %0d of %0d writebacks and %0d of %0d stores",
                wb_idx, WB_COUNT, st_idx, ST_COUNT));
        end

        // core spins on the last j and the monitor flags anything extra
        repeat (QUIET_CYCLES) @(posedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
